// ==== logic/rv_pkg.sv ====
// word and field types, opcodes, funct3 codes and datapath select codes
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t; // data and address word
	typedef logic [4:0] reg_addr_t; // register index
	typedef logic [6:0] opcode_t; // major opcode field
	typedef logic [0:0] op1_sel_t;
	typedef logic [1:0] op2_sel_t;
	typedef logic [1:0] alu_mode_t;
	typedef logic [1:0] wb_sel_t;

	localparam opcode_t OPC_OP = 7'b0110011; // r-type alu
	localparam opcode_t OPC_OPIMM = 7'b0010011; // i-type alu
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_AUIPC = 7'b0010111;

	localparam logic [2:0] F3_ADD = 3'b000; // add, sub and beq share this code
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	localparam op1_sel_t OP1_RS1 = 1'b0;
	localparam op1_sel_t OP1_PC = 1'b1; // auipc base

	localparam op2_sel_t OP2_RS2 = 2'd0;
	localparam op2_sel_t OP2_IMM = 2'd1;
	localparam op2_sel_t OP2_ZERO = 2'd2; // lui, immediate passes straight through

	localparam alu_mode_t ALU_REG = 2'd0; // funct3 plus funct7 bit 5
	localparam alu_mode_t ALU_IMM = 2'd1; // funct3 only
	localparam alu_mode_t ALU_ADD = 2'd2; // address and upper-imm math

	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MEM = 2'd1;
	localparam wb_sel_t WB_PC4 = 2'd2; // link value

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== logic/ctrl_if.sv ====
// decoded control bundle with decoder and consumer modports
`default_nettype none

interface ctrl_if;
	import rv_pkg::*;

	op1_sel_t op1sel; // rs1 or pc
	op2_sel_t op2sel; // rs2, imm or zero
	alu_mode_t alu_mode;
	logic memwr; // sw
	logic memrd; // lw
	logic regwr;
	wb_sel_t wbsel;
	logic willjmp; // jal, or beq taken

	modport dec (output op1sel, op2sel, alu_mode, memwr, memrd, regwr, wbsel, willjmp);
	modport exe (input op1sel, op2sel, alu_mode, wbsel);
	modport rf (input regwr);
	modport mem (input memrd, memwr);
	modport pc (input willjmp);
endinterface

`default_nettype wire

// ==== logic/decoder.sv ====
// decoder: opcode and funct bits to datapath controls and jump decision
`default_nettype none

module decoder (
	input rv_pkg::opcode_t opcode,
	input logic [2:0] funct3,
	input logic funct7_5,
	input logic equal, // rs1 == rs2 from exec unit
	ctrl_if.dec ctrl
);
	import rv_pkg::*;

	always_comb
	begin
		ctrl.op1sel = OP1_RS1; // defaults form a no-op
		ctrl.op2sel = OP2_RS2;
		ctrl.alu_mode = ALU_ADD;
		ctrl.memwr = 1'b0;
		ctrl.memrd = 1'b0;
		ctrl.regwr = 1'b0;
		ctrl.wbsel = WB_ALU;
		ctrl.willjmp = 1'b0;
		case (opcode)
			OPC_OP:
			begin
				ctrl.alu_mode = funct7_5 ? ALU_REG : ALU_IMM; // bit 5 only matters for sub
				ctrl.regwr = 1'b1;
			end
			OPC_OPIMM:
			begin
				ctrl.op2sel = OP2_IMM;
				ctrl.alu_mode = ALU_IMM; // imm[11:5] is not funct7 here
				ctrl.regwr = 1'b1;
			end
			OPC_LOAD:
			begin
				ctrl.op2sel = OP2_IMM; // rs1 + offset
				ctrl.memrd = 1'b1;
				ctrl.regwr = 1'b1; // lands on the retire edge
				ctrl.wbsel = WB_MEM;
			end
			OPC_STORE:
			begin
				ctrl.op2sel = OP2_IMM; // s-type offset
				ctrl.memwr = 1'b1;
			end
			OPC_BRANCH:
			begin
				// only beq is decoded, other funct3 values fall through
				ctrl.willjmp = (funct3 == F3_ADD) && equal;
			end
			OPC_JAL:
			begin
				ctrl.regwr = 1'b1;
				ctrl.wbsel = WB_PC4; // link always into rd
				ctrl.willjmp = 1'b1;
			end
			OPC_LUI:
			begin
				ctrl.op2sel = OP2_ZERO; // imm + 0
				ctrl.regwr = 1'b1;
			end
			OPC_AUIPC:
			begin
				ctrl.op1sel = OP1_PC;
				ctrl.op2sel = OP2_IMM; // pc + upper imm
				ctrl.regwr = 1'b1;
			end
			default:
			begin
				ctrl.regwr = 1'b0; // unknown opcode, pc just steps
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
// immediate generator for i, s, b, u and j formats
`default_nettype none

module imm_gen (
	input rv_pkg::word_t instr,
	output rv_pkg::word_t imm
);
	import rv_pkg::*;

	opcode_t opcode;

	assign opcode = instr[6:0];

	always_comb
	begin
		case (opcode)
			OPC_STORE:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // s-type
			OPC_BRANCH:
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0}; // b-type, even offset
			OPC_LUI, OPC_AUIPC:
				imm = {instr[31:12], 12'h000}; // u-type, low bits zero
			OPC_JAL:
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0}; // j-type
			default:
				imm = {{20{instr[31]}}, instr[31:20]}; // i-type for opimm and load
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/regfile.sv ====
// 32x32 register file, two async read ports, one write port held by stall
`default_nettype none

module regfile (
	input logic clk,
	input logic rst_n,
	input rv_pkg::reg_addr_t rs1_addr,
	input rv_pkg::reg_addr_t rs2_addr,
	input rv_pkg::reg_addr_t rd_addr,
	input rv_pkg::word_t wb_data,
	input logic stall, // memory access still open
	ctrl_if.rf ctrl,
	output rv_pkg::word_t rs1_data,
	output rv_pkg::word_t rs2_data
);
	import rv_pkg::*;

	word_t regs [32];

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr]; // x0 hardwired
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (ctrl.regwr && !stall && (rd_addr != 5'd0))
			regs[rd_addr] <= wb_data; // retire edge only
	end

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
// execute stage: operand muxes, alu, equality compare, write-back mux
`default_nettype none

module exec_unit (
	input rv_pkg::word_t pc,
	input rv_pkg::word_t rs1_data,
	input rv_pkg::word_t rs2_data,
	input rv_pkg::word_t imm,
	input rv_pkg::word_t mem_rdata, // straight from prdata
	input logic [2:0] funct3,
	input logic funct7_5,
	ctrl_if.exe ctrl,
	output rv_pkg::word_t alu_result,
	output rv_pkg::word_t wb_data,
	output logic equal
);
	import rv_pkg::*;

	word_t op_a;
	word_t op_b;
	logic do_sub;

	always_comb
	begin
		if (ctrl.op2sel == OP2_ZERO)
			op_a = imm; // lui, result is the upper imm itself
		else if (ctrl.op1sel == OP1_PC)
			op_a = pc;
		else
			op_a = rs1_data;
		case (ctrl.op2sel)
			OP2_IMM: op_b = imm;
			OP2_ZERO: op_b = '0;
			default: op_b = rs2_data;
		endcase
	end

	assign do_sub = (ctrl.alu_mode == ALU_REG) && funct7_5; // never for immediates

	always_comb
	begin
		if (ctrl.alu_mode == ALU_ADD)
			alu_result = op_a + op_b; // addresses, lui, auipc
		else
			case (funct3)
				F3_ADD: alu_result = do_sub ? (op_a - op_b) : (op_a + op_b);
				F3_XOR: alu_result = op_a ^ op_b;
				F3_OR: alu_result = op_a | op_b;
				F3_AND: alu_result = op_a & op_b;
				default: alu_result = op_a + op_b; // unsupported funct3
			endcase
	end

	assign equal = (rs1_data == rs2_data); // beq decision in decoder

	always_comb
	begin
		case (ctrl.wbsel)
			WB_MEM: wb_data = mem_rdata;
			WB_PC4: wb_data = pc + 32'd4; // jal link
			default: wb_data = alu_result;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
// program counter register and next-pc select
`default_nettype none

module pc_unit (
	input logic clk,
	input logic rst_n,
	input rv_pkg::word_t imm, // branch or jal offset
	input logic stall,
	ctrl_if.pc ctrl,
	output rv_pkg::word_t pc
);
	import rv_pkg::*;

	word_t pc_nxt;

	assign pc_nxt = ctrl.willjmp ? (pc + imm) : (pc + 32'd4); // pc-relative target

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= RESET_PC;
		else if (!stall)
			pc <= pc_nxt; // frozen while apb transfer is open
	end

endmodule

`default_nettype wire

// ==== logic/apb_data_port.sv ====
// apb master for lw and sw, drives the core stall
`default_nettype none

module apb_data_port (
	input logic clk,
	input logic rst_n,
	input rv_pkg::word_t addr, // alu result
	input rv_pkg::word_t wdata, // rs2
	ctrl_if.mem ctrl,
	output rv_pkg::word_t rdata,
	output logic stall,
	output rv_pkg::word_t paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output rv_pkg::word_t pwdata,
	input rv_pkg::word_t prdata,
	input logic pready
);
	import rv_pkg::*;

	typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

	apb_state_t state;
	apb_state_t phase; // bus phase seen this cycle
	apb_state_t state_nxt;

	always_comb
	begin
		phase = state;
		if ((state == IDLE) && (ctrl.memrd || ctrl.memwr))
			phase = SETUP; // setup overlaps the decode cycle
	end

	always_comb
	begin
		case (phase)
			SETUP: state_nxt = ACCESS;
			ACCESS: state_nxt = pready ? IDLE : ACCESS; // wait states hold here
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	assign psel = (phase != IDLE);
	assign penable = (phase == ACCESS);
	assign pwrite = psel && ctrl.memwr;
	assign paddr = addr; // stable, pc held by stall
	assign pwdata = wdata;
	assign rdata = prdata; // sampled by regfile on the pready edge
	assign stall = (phase == SETUP) || ((phase == ACCESS) && !pready);

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
// rv32i subset core top: decoder, imm gen, regfile, exec, pc and apb port
`default_nettype none

module rv_core (
	input logic clk,
	input logic rst_n,
	output rv_pkg::word_t imem_addr,
	input rv_pkg::word_t imem_rdata, // combinational instruction fetch
	output rv_pkg::word_t paddr,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output rv_pkg::word_t pwdata,
	input rv_pkg::word_t prdata,
	input logic pready
);
	import rv_pkg::*;

	ctrl_if ctrl ();

	word_t imm;
	word_t rs1_data;
	word_t rs2_data;
	word_t alu_result;
	word_t wb_data;
	word_t mem_rdata;
	word_t pc;
	logic equal;
	logic stall;

	assign imem_addr = pc;

	decoder u_decoder (.opcode(imem_rdata[6:0]), .funct3(imem_rdata[14:12]),
		.funct7_5(imem_rdata[30]), .equal(equal), .ctrl(ctrl.dec));

	imm_gen u_imm_gen (.instr(imem_rdata), .imm(imm));

	regfile u_regfile (.clk(clk), .rst_n(rst_n), .rs1_addr(imem_rdata[19:15]),
		.rs2_addr(imem_rdata[24:20]), .rd_addr(imem_rdata[11:7]), .wb_data(wb_data),
		.stall(stall), .ctrl(ctrl.rf), .rs1_data(rs1_data), .rs2_data(rs2_data));

	exec_unit u_exec_unit (.pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
		.mem_rdata(mem_rdata), .funct3(imem_rdata[14:12]), .funct7_5(imem_rdata[30]),
		.ctrl(ctrl.exe), .alu_result(alu_result), .wb_data(wb_data), .equal(equal));

	pc_unit u_pc_unit (.clk(clk), .rst_n(rst_n), .imm(imm), .stall(stall),
		.ctrl(ctrl.pc), .pc(pc));

	apb_data_port u_apb_data_port (.clk(clk), .rst_n(rst_n), .addr(alu_result),
		.wdata(rs2_data), .ctrl(ctrl.mem), .rdata(mem_rdata), .stall(stall),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready));

endmodule

`default_nettype wire

// ==== verif/tb_rv_core.sv ====
// rv_core testbench with instruction rom, apb slave memory, protocol monitor, tests and watchdog
`default_nettype none

module tb_rv_core;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int PROG_WORDS = 70; // all five programs with their self loops
	localparam int NUM_TESTS = 5;
	localparam int MAX_CPI = 6; // sw with three wait states needs 5
	localparam int WATCHDOG_NS = (PROG_WORDS * MAX_CPI + NUM_TESTS * (RESET_CYCLES + 2))
		* CLK_PERIOD;
	localparam logic [31:0] SELF_LOOP = 32'h0000_006f; // jal x0, 0
	localparam logic [6:0] OPIMM = 7'b0010011;
	localparam logic [6:0] LOAD = 7'b0000011;
	localparam logic [6:0] LUI = 7'b0110111;
	localparam logic [6:0] AUIPC = 7'b0010111;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	logic [31:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata = '0;
	logic pready = 1'b0;

	logic [31:0] rom [64];
	logic [31:0] mem [64]; // slave data words
	int wait_tbl [256]; // wait states per transfer, drawn up front
	logic [31:0] wr_addr_q [$]; // writes seen on the bus
	logic [31:0] wr_data_q [$];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] xf_addr;
	logic [31:0] xf_wdata;
	logic [31:0] xf_pc;
	logic xf_write;
	logic in_xfer = 1'b0;
	int waits = 0;
	int xfer_count = 0;
	int prog_len = 0;
	int proto_errs = 0; // counted by the slave only
	int check_errs = 0; // counted by the test tasks only
	int tests_run = 0;
	int tests_failed = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	rv_core u_rv_core (.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready));

	assign imem_rdata = rom[imem_addr[7:2]]; // combinational fetch

	function automatic logic [31:0] r_type(input logic f7_5, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, f7_5, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // sw
	endfunction

	function automatic logic [31:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011}; // beq
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return (a * 32'h0001_0001) ^ 32'h3c5a_96e1; // every address bit matters
	endfunction

	task automatic bus_error(input string msg);
		$display("protocol error at %0t ns: %s", $time, msg);
		proto_errs++;
	endtask

	task automatic bus_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED %s: got %h expected %h", name, got, exp);
		proto_errs++;
	endtask

	task automatic check_error(input string msg);
		$display("check failed at %0t ns: %s", $time, msg);
		check_errs++;
	endtask

	task automatic check_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("FAILED %s: got %h expected %h", name, got, exp);
		check_errs++;
	endtask

	// apb slave with drawn wait states that also watches the master side
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 64; i++)
				mem[i] = fill_word(32'(i) << 2); // preset while the core is held
			wr_addr_q.delete();
			wr_data_q.delete();
			in_xfer = 1'b0;
			pready <= 1'b0;
		end
		else if (psel && !penable)
		begin
			if (in_xfer)
				bus_error("setup phase seen while a transfer was still open");
			if ((paddr > 32'd252) || (paddr[1:0] != 2'b00))
				bus_error("paddr outside the slave or not word aligned");
			xf_addr = paddr; // must hold until pready
			xf_wdata = pwdata;
			xf_write = pwrite;
			xf_pc = imem_addr;
			waits = wait_tbl[xfer_count % 256];
			xfer_count++;
			in_xfer = 1'b1;
			pready <= (waits == 0);
			prdata <= mem[paddr[7:2]];
		end
		else if (psel && penable)
		begin
			if (!in_xfer)
				bus_error("penable high without a setup cycle before it");
			if (paddr !== xf_addr)
				bus_mismatch("paddr", paddr, xf_addr);
			if (pwrite !== xf_write)
				bus_mismatch("pwrite", {31'd0, pwrite}, {31'd0, xf_write});
			if (xf_write && (pwdata !== xf_wdata))
				bus_mismatch("pwdata", pwdata, xf_wdata);
			if (imem_addr !== xf_pc)
				bus_mismatch("imem_addr", imem_addr, xf_pc); // pc must hold
			if (pready)
			begin
				if (pwrite)
				begin
					mem[paddr[7:2]] = pwdata;
					wr_addr_q.push_back(paddr);
					wr_data_q.push_back(pwdata);
				end
				in_xfer = 1'b0;
				pready <= 1'b0;
			end
			else
			begin
				waits--;
				pready <= (waits == 0); // last wait state ends here
			end
		end
		else if (in_xfer || penable)
			bus_error("transfer dropped before pready");
	end

	task automatic put(input logic [31:0] instr);
		rom[prog_len] = instr;
		prog_len++;
	endtask

	task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic begin_test();
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk); // core already held when the rom changes
		for (int i = 0; i < 64; i++)
			rom[i] = SELF_LOOP; // stray fetches spin in place
		prog_len = 0;
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	// releases reset, waits for every expected store and compares the log
	task automatic run_and_check(input string name);
		int errs_before;
		errs_before = proto_errs + check_errs;
		put(SELF_LOOP);
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		if ((psel !== 1'b0) || (penable !== 1'b0))
			check_error("psel or penable high while the core is in reset");
		if (imem_addr !== 32'd0)
			check_mismatch("imem_addr", imem_addr, 32'd0);
		@(posedge clk);
		rst_n <= 1'b1;
		while (wr_addr_q.size() < exp_addr_q.size())
			@(negedge clk); // watchdog covers a missing store
		for (int i = 0; i < exp_addr_q.size(); i++)
		begin
			if (wr_addr_q[i] !== exp_addr_q[i])
				check_mismatch("paddr", wr_addr_q[i], exp_addr_q[i]);
			if (wr_data_q[i] !== exp_data_q[i])
				check_mismatch("pwdata", wr_data_q[i], exp_data_q[i]);
		end
		tests_run++;
		if (proto_errs + check_errs == errs_before)
			$display("test %s: ok, %0d stores", name, exp_addr_q.size());
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name,
				proto_errs + check_errs - errs_before);
		end
	endtask

	task automatic alu_and_store(input logic [31:0] instr, input int slot,
		input logic [31:0] value);
		put(instr); // result lands in x3
		put(s_type(5'd3, 5'd0, 12'(slot * 4)));
		expect_write(32'(slot * 4), value);
	endtask

	task automatic alu_ops();
		logic [31:0] a;
		logic [31:0] b;
		a = {20'h12345, 12'h000} + sext12(12'h678);
		b = {20'hff00f, 12'h000} + sext12(12'hff0); // negative addi
		begin_test();
		put(u_type(LUI, 5'd1, 20'h12345));
		put(i_type(OPIMM, 3'b000, 5'd1, 5'd1, 12'h678));
		put(u_type(LUI, 5'd2, 20'hff00f));
		put(i_type(OPIMM, 3'b000, 5'd2, 5'd2, 12'hff0));
		alu_and_store(r_type(1'b0, 3'b000, 5'd3, 5'd1, 5'd2), 0, a + b);
		alu_and_store(r_type(1'b1, 3'b000, 5'd3, 5'd1, 5'd2), 1, a - b);
		alu_and_store(r_type(1'b0, 3'b111, 5'd3, 5'd1, 5'd2), 2, a & b);
		alu_and_store(r_type(1'b0, 3'b110, 5'd3, 5'd1, 5'd2), 3, a | b);
		alu_and_store(r_type(1'b0, 3'b100, 5'd3, 5'd1, 5'd2), 4, a ^ b);
		alu_and_store(i_type(OPIMM, 3'b111, 5'd3, 5'd1, 12'h0f0), 5, a & sext12(12'h0f0));
		alu_and_store(i_type(OPIMM, 3'b110, 5'd3, 5'd1, 12'h800), 6, a | sext12(12'h800));
		alu_and_store(i_type(OPIMM, 3'b100, 5'd3, 5'd1, 12'h7ff), 7, a ^ sext12(12'h7ff));
		// imm bit 10 sits where funct7 bit 5 would be so addi must still add
		alu_and_store(i_type(OPIMM, 3'b000, 5'd3, 5'd1, 12'h400), 8, a + sext12(12'h400));
		run_and_check("alu");
	endtask

	task automatic load_use();
		begin_test();
		put(i_type(OPIMM, 3'b000, 5'd5, 5'd0, 12'h020)); // base 0x20
		put(i_type(LOAD, 3'b010, 5'd6, 5'd5, 12'h008));
		put(i_type(OPIMM, 3'b000, 5'd7, 5'd6, 12'h123)); // uses the load at once
		put(s_type(5'd7, 5'd5, 12'h00c));
		put(i_type(LOAD, 3'b010, 5'd8, 5'd5, 12'hffc)); // negative offset
		put(i_type(OPIMM, 3'b000, 5'd8, 5'd8, 12'hfff));
		put(s_type(5'd8, 5'd5, 12'h000));
		expect_write(32'h20 + 32'h00c, fill_word(32'h20 + 32'h008) + 32'h123);
		expect_write(32'h20, fill_word(32'h20 + sext12(12'hffc)) + sext12(12'hfff));
		run_and_check("load_use");
	endtask

	task automatic beq_paths();
		logic [31:0] v1;
		logic [31:0] v2;
		logic [31:0] v3;
		v1 = 32'd5;
		v2 = 32'd5;
		v3 = 32'd7;
		begin_test();
		put(i_type(OPIMM, 3'b000, 5'd1, 5'd0, v1[11:0]));
		put(i_type(OPIMM, 3'b000, 5'd2, 5'd0, v2[11:0]));
		put(i_type(OPIMM, 3'b000, 5'd3, 5'd0, v3[11:0]));
		put(b_type(5'd1, 5'd2, 13'd12)); // x1 == x2 jumps over the marker
		put(i_type(OPIMM, 3'b000, 5'd4, 5'd0, 12'hbad));
		put(s_type(5'd4, 5'd0, 12'h000));
		put(i_type(OPIMM, 3'b000, 5'd4, 5'd0, 12'h111));
		put(s_type(5'd4, 5'd0, 12'h000));
		put(b_type(5'd1, 5'd3, 13'd12)); // x1 != x3 falls through
		put(i_type(OPIMM, 3'b000, 5'd4, 5'd0, 12'h222));
		put(s_type(5'd4, 5'd0, 12'h004));
		put(i_type(OPIMM, 3'b000, 5'd4, 5'd0, 12'h333));
		put(s_type(5'd4, 5'd0, 12'h008));
		if (v1 != v2)
			expect_write(32'h0, sext12(12'hbad));
		expect_write(32'h0, 32'h111);
		if (v1 != v3)
			expect_write(32'h4, 32'h222);
		expect_write(32'h8, 32'h333);
		run_and_check("beq");
	endtask

	task automatic jal_auipc_lui();
		begin_test();
		put(i_type(OPIMM, 3'b000, 5'd1, 5'd0, 12'h001));
		put(j_type(5'd5, 21'd8)); // at 0x4 with link into x5
		put(s_type(5'd1, 5'd0, 12'h03c)); // skipped by the jump
		put(u_type(AUIPC, 5'd6, 20'h00012)); // at 0xc
		put(u_type(LUI, 5'd7, 20'habcde));
		put(s_type(5'd5, 5'd0, 12'h000));
		put(s_type(5'd6, 5'd0, 12'h004));
		put(s_type(5'd7, 5'd0, 12'h008));
		expect_write(32'h0, 32'h4 + 32'h4);
		expect_write(32'h4, 32'hc + {20'h00012, 12'h000});
		expect_write(32'h8, {20'habcde, 12'h000});
		run_and_check("jal_auipc_lui");
	endtask

	task automatic apb_wait_states();
		begin_test();
		put(i_type(OPIMM, 3'b000, 5'd1, 5'd0, 12'h080)); // copy target
		for (int i = 0; i < 6; i++)
		begin
			put(i_type(LOAD, 3'b010, 5'd2, 5'd0, 12'(i * 4)));
			put(s_type(5'd2, 5'd1, 12'(i * 4))); // lw then sw back to back
			expect_write(32'h80 + 32'(i * 4), fill_word(32'(i * 4)));
		end
		put(s_type(5'd1, 5'd0, 12'h040));
		put(s_type(5'd1, 5'd0, 12'h044)); // sw then sw
		expect_write(32'h40, 32'h80);
		expect_write(32'h44, 32'h80);
		run_and_check("apb_waits");
	endtask

	initial
	begin
		void'($urandom(32'h2e3a_caa0));
		for (int i = 0; i < 64; i++)
			rom[i] = SELF_LOOP; // fetches before the first test spin in place
		for (int i = 0; i < 256; i++)
			wait_tbl[i] = $urandom % 4; // 0 to 3 wait states
		alu_ops();
		load_use();
		beq_paths();
		jal_auipc_lui();
		apb_wait_states();
		$display("tests run %0d, failed %0d, check errors %0d, protocol errors %0d",
			tests_run, tests_failed, check_errs, proto_errs);
		if ((tests_failed == 0) && (proto_errs + check_errs == 0))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a test never saw all its stores", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/rv_pkg.sv
logic/ctrl_if.sv
logic/decoder.sv
logic/imm_gen.sv
logic/regfile.sv
logic/exec_unit.sv
logic/pc_unit.sv
logic/apb_data_port.sv
logic/rv_core.sv
verif/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_rv_core -f filelist.f -o sim_rv_core; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_rv_core > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
	exit 1
fi
exit 0
